// ==== build.f ====
src/aib_tx_pkg.sv
src/tx_chnl_ctrl.sv
src/tx_phcomp_fifo.sv
src/tx_out_stage.sv
src/aib_tx_chnl.sv
bench/tb_clock_gen.sv
bench/tb_aib_tx_chnl.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_aib_tx_chnl
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_aib_tx_chnl.sv ====
`timescale 1ns/100ps
/* Table-driven testbench for the AIB transmit channel, with an ordered
   queue of expected beats and a model of the FIFO fill count */
module tb_aib_tx_chnl;
  import aib_tx_pkg::*;

  localparam int depth  = 8;
  localparam int n_rows = 10;

  typedef enum int {p_user, p_lpbk, p_reg, p_reg_rx, p_din} path_e;

  typedef struct {
    fifo_mode_e fm;
    lpbk_mode_e lm;
    logic [2:0] dly;
    int         words;  // Words, or cycles on the register paths
    bit         drain;  // Wait for all beats at the end
    path_e      src;    // Expected source of dout
  } row_t;

  logic              clk;
  logic              reset;
  logic              row_reset;
  logic [word_w-1:0] data_in;
  logic              req;
  logic              ack;
  logic [beat_w-1:0] din;
  logic [beat_w-1:0] rx_reg_dout;
  logic [word_w-1:0] rx_fifo_data_out;
  logic              rx_fifo_valid;
  fifo_mode_e        fifo_mode;
  lpbk_mode_e        lpbk_mode;
  logic [2:0]        rd_delay;
  logic [beat_w-1:0] dout;
  logic              dout_valid;

  row_t              rows [n_rows];
  path_e             path;
  bit                dbl;
  bit                mon_on;
  bit                ack_q;
  bit                lpbk_pend;
  bit                prev_ok;
  logic [word_w-1:0] lpbk_word;
  logic [beat_w-1:0] prev_src;
  logic [beat_w-1:0] exp_q [$];
  bit                last_q [$];  // Beat that pops its word
  int                model_cnt;
  int                acked;
  int                val_errs;
  int                misc_errs;

  tb_clock_gen u_clk (
    .row_reset (row_reset),
    .clk       (clk),
    .reset     (reset)
  );

  aib_tx_chnl #(
    .fifo_depth (depth)
  ) u_dut (
    .m_ns_fwd_clk           (clk),
    .reset                  (reset),
    .data_in                (data_in),
    .req                    (req),
    .ack                    (ack),
    .din                    (din),
    .rx_reg_dout            (rx_reg_dout),
    .rx_fifo_data_out       (rx_fifo_data_out),
    .rx_fifo_valid          (rx_fifo_valid),
    .r_tx_fifo_mode         (fifo_mode),
    .r_tx_adapter_lpbk_mode (lpbk_mode),
    .r_tx_phcomp_rd_delay   (rd_delay),
    .dout                   (dout),
    .dout_valid             (dout_valid)
  );

  function automatic logic [word_w-1:0] rand_word();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[word_w-1:0];
  endfunction

  function automatic void push_word(logic [word_w-1:0] w);
    exp_q.push_back(w[beat_w-1:0]);
    last_q.push_back(!dbl);
    if (dbl) begin  // High half follows
      exp_q.push_back(w[word_w-1:beat_w]);
      last_q.push_back(1'b1);
    end
  endfunction

  task automatic report_fail(input string msg);
    val_errs++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_ack(input logic level);
    int waited;
    waited = 0;
    while (ack !== level && waited < 64) begin
      step();
      waited++;
    end
    if (ack !== level) begin
      misc_errs++;
      $display("Handshake stuck: ack did not go to %b by %0t", level, $time);
    end
  endtask

  task automatic send_word();
    data_in = rand_word();
    req = 1'b1;
    step();
    wait_ack(1'b1);
    req = 1'b0;  // Dropped as soon as ack is seen
    wait_ack(1'b0);
  endtask

  // Outputs sampled mid-cycle, one edge of history kept
  always @(negedge clk) begin : monitor
    int wr_now;
    int rd_now;
    if (mon_on) begin
      wr_now = 0;
      rd_now = 0;
      if (ack && !ack_q) begin
        if (path != p_user || model_cnt >= depth)
          report_fail("ack rose while the path was closed");
        wr_now = 1;
        acked++;
        push_word(data_in);
      end
      if (lpbk_pend && model_cnt >= depth) begin
        misc_errs++;
        $display("Loopback word dropped on a full FIFO at %0t", $time);
      end else if (lpbk_pend) begin
        wr_now = 1;
        push_word(lpbk_word);
      end
      if (path == p_user || path == p_lpbk) begin
        if (dout_valid && exp_q.size() == 0)
          report_fail($sformatf("unexpected beat %h", dout));
        else if (dout_valid) begin
          if (dout !== exp_q[0])
            report_fail($sformatf("dout %h, expected %h", dout, exp_q[0]));
          void'(exp_q.pop_front());
          rd_now = last_q.pop_front();
        end
      end else if (prev_ok && (dout_valid !== 1'b1 || dout !== prev_src))
        report_fail($sformatf("dout %h valid %b, expected %h", dout, dout_valid, prev_src));
      prev_ok   = 1'b1;
      prev_src  = (path == p_din) ? din :
                  (path == p_reg_rx) ? rx_reg_dout : data_in[beat_w-1:0];
      model_cnt = model_cnt + wr_now - rd_now;
      ack_q     = ack;
      lpbk_pend = (path == p_lpbk) && rx_fifo_valid;
      lpbk_word = rx_fifo_data_out;
    end
  end

  task automatic run_row(input int r);
    int i;
    step();
    row_reset = 1'b1;
    mon_on    = 1'b0;
    req       = 1'b0;
    fifo_mode = rows[r].fm;
    lpbk_mode = rows[r].lm;
    rd_delay  = rows[r].dly;
    path      = rows[r].src;
    dbl       = (rows[r].fm == fifo_double);
    exp_q.delete();
    last_q.delete();
    model_cnt = 0;
    acked     = 0;
    ack_q     = 1'b0;
    lpbk_pend = 1'b0;
    prev_ok   = 1'b0;
    repeat (4) step();
    if (ack !== 1'b0 || dout_valid !== 1'b0 || dout !== '0)
      report_fail($sformatf("reset state ack %b valid %b dout %h", ack, dout_valid, dout));
    row_reset = 1'b0;
    mon_on    = 1'b1;
    if (path == p_user) begin
      for (i = 0; i < rows[r].words; i++)
        send_word();
    end else begin
      req = 1'b1;  // Offered but never acknowledged
      for (i = 0; i < 3 * rows[r].words; i++) begin
        data_in          = rand_word();
        din              = beat_w'(rand_word());
        rx_reg_dout      = beat_w'(rand_word());
        rx_fifo_data_out = rand_word();
        rx_fifo_valid    = (path == p_lpbk) && (i % 3 == 0);  // Below the read rate
        step();
      end
      rx_fifo_valid = 1'b0;
    end
    for (i = 0; rows[r].drain && exp_q.size() != 0 && i < 20 * rows[r].words; i++)
      step();
    repeat (4) step();  // Room for stray beats
    if (exp_q.size() != 0) begin
      misc_errs++;
      $display("Lost beats: %0d expected beats never came out in test %0d", exp_q.size(), r);
    end
    if (path == p_user && acked != rows[r].words) begin
      misc_errs++;
      $display("Handshake stuck: %0d of %0d words taken in test %0d", acked, rows[r].words, r);
    end
    req = 1'b0;
  endtask

  initial begin : watchdog
    int total;
    total = 0;
    @(posedge clk);
    for (int i = 0; i < n_rows; i++)
      total += rows[i].words;
    repeat (total * 20 + 200) @(posedge clk);
    $display("Timeout: the run did not finish, %0d value errors, %0d other errors",
             val_errs, misc_errs);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    void'($urandom(61));
    data_in          = '0;
    din              = '0;
    rx_reg_dout      = '0;
    rx_fifo_data_out = '0;
    req              = 1'b0;
    rx_fifo_valid    = 1'b0;
    mon_on           = 1'b0;
    val_errs         = 0;
    misc_errs        = 0;
    row_reset = 1'b1;
    fifo_mode = fifo_single;
    lpbk_mode = lpbk_none;
    rd_delay  = 3'd0;
    rows[0] = '{fifo_single, lpbk_none,   3'd0, 10, 1'b1, p_user};
    rows[1] = '{fifo_single, lpbk_none,   3'd5, 10, 1'b1, p_user};
    rows[2] = '{fifo_double, lpbk_none,   3'd2, 10, 1'b1, p_user};
    rows[3] = '{fifo_rsvd,   lpbk_none,   3'd3,  6, 1'b1, p_user};
    rows[4] = '{fifo_double, lpbk_none,   3'd7, 12, 1'b1, p_user};  // Back-pressure
    rows[5] = '{fifo_reg,    lpbk_none,   3'd0, 20, 1'b0, p_reg};
    rows[6] = '{fifo_single, lpbk_3_reg,  3'd0, 20, 1'b0, p_reg_rx};
    rows[7] = '{fifo_double, lpbk_2,      3'd0, 20, 1'b0, p_din};
    rows[8] = '{fifo_single, lpbk_3_fifo, 3'd1, 10, 1'b1, p_lpbk};
    rows[9] = '{fifo_double, lpbk_3_fifo, 3'd4, 10, 1'b1, p_lpbk};
    for (int r = 0; r < n_rows; r++)
      run_row(r);
    mon_on = 1'b0;
    $display("Done: %0d value errors, %0d other errors", val_errs, misc_errs);
    if (val_errs == 0 && misc_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps
/* Testbench clock of 4 ns period, power-on reset for 4 cycles */
module tb_clock_gen (
  input  logic row_reset,  // Extra reset between tests
  output logic clk,
  output logic reset
);
  logic por;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    por = 1'b1;
    repeat (4) @(posedge clk);
    #1 por = 1'b0;
  end

  assign reset = por || row_reset;

endmodule

// ==== src/aib_tx_chnl.sv ====
`timescale 1ns/100ps
/* AIB adapter transmit channel top: control block, phase-compensation
   FIFO and output stage on the single m_ns_fwd_clk domain */
module aib_tx_chnl #(
  parameter int fifo_depth = 8
) (
  input  logic                          m_ns_fwd_clk,
  input  logic                          reset,
  input  logic [aib_tx_pkg::word_w-1:0] data_in,
  input  logic                          req,
  output logic                          ack,
  input  logic [aib_tx_pkg::beat_w-1:0] din,               // Loopback 2 source
  input  logic [aib_tx_pkg::beat_w-1:0] rx_reg_dout,       // Loopback 3 register source
  input  logic [aib_tx_pkg::word_w-1:0] rx_fifo_data_out,  // Loopback 3 FIFO source
  input  logic                          rx_fifo_valid,
  input  aib_tx_pkg::fifo_mode_e        r_tx_fifo_mode,
  input  aib_tx_pkg::lpbk_mode_e        r_tx_adapter_lpbk_mode,
  input  logic [2:0]                    r_tx_phcomp_rd_delay,
  output logic [aib_tx_pkg::beat_w-1:0] dout,
  output logic                          dout_valid
);
  import aib_tx_pkg::*;

  logic              wr_en;
  logic              wr_sel_lpbk;
  logic              rd_en;
  logic              half_sel;
  logic              beat_valid;
  logic              reg_lpbk;
  logic              full;
  logic              empty;
  logic [word_w-1:0] rd_data;
  out_src_e          out_src;

  tx_chnl_ctrl u_ctrl (
    .m_ns_fwd_clk           (m_ns_fwd_clk),
    .reset                  (reset),
    .req                    (req),
    .ack                    (ack),
    .r_tx_fifo_mode         (r_tx_fifo_mode),
    .r_tx_adapter_lpbk_mode (r_tx_adapter_lpbk_mode),
    .r_tx_phcomp_rd_delay   (r_tx_phcomp_rd_delay),
    .rx_fifo_valid          (rx_fifo_valid),
    .full                   (full),
    .empty                  (empty),
    .wr_en                  (wr_en),
    .wr_sel_lpbk            (wr_sel_lpbk),
    .rd_en                  (rd_en),
    .half_sel               (half_sel),
    .beat_valid             (beat_valid),
    .reg_lpbk               (reg_lpbk),
    .out_src                (out_src)
  );

  tx_phcomp_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .m_ns_fwd_clk     (m_ns_fwd_clk),
    .reset            (reset),
    .wr_en            (wr_en),
    .wr_sel_lpbk      (wr_sel_lpbk),
    .data_in          (data_in),
    .rx_fifo_data_out (rx_fifo_data_out),
    .rd_en            (rd_en),
    .rd_data          (rd_data),
    .full             (full),
    .empty            (empty)
  );

  tx_out_stage u_out (
    .m_ns_fwd_clk (m_ns_fwd_clk),
    .reset        (reset),
    .out_src      (out_src),
    .reg_lpbk     (reg_lpbk),
    .data_in_lo   (data_in[beat_w-1:0]),  // Register mode sends beat 0 only
    .rx_reg_dout  (rx_reg_dout),
    .din          (din),
    .rd_data      (rd_data),
    .half_sel     (half_sel),
    .beat_valid   (beat_valid),
    .dout         (dout),
    .dout_valid   (dout_valid)
  );

endmodule

// ==== src/tx_out_stage.sv ====
`timescale 1ns/100ps
/* Transmit output stage: register path select, FIFO half pick
   and the registered dout with dout_valid */
module tx_out_stage (
  input  logic                          m_ns_fwd_clk,
  input  logic                          reset,
  input  aib_tx_pkg::out_src_e          out_src,
  input  logic                          reg_lpbk,
  input  logic [aib_tx_pkg::beat_w-1:0] data_in_lo,
  input  logic [aib_tx_pkg::beat_w-1:0] rx_reg_dout,
  input  logic [aib_tx_pkg::beat_w-1:0] din,
  input  logic [aib_tx_pkg::word_w-1:0] rd_data,
  input  logic                          half_sel,
  input  logic                          beat_valid,
  output logic [aib_tx_pkg::beat_w-1:0] dout,
  output logic                          dout_valid
);
  import aib_tx_pkg::*;

  logic [beat_w-1:0] reg_din;    // Register path source
  logic [beat_w-1:0] fifo_beat;  // Current FIFO half
  logic [beat_w-1:0] dout_nxt;
  logic              valid_nxt;

  assign reg_din   = reg_lpbk ? rx_reg_dout : data_in_lo;
  assign fifo_beat = half_sel ? rd_data[word_w-1:beat_w] : rd_data[beat_w-1:0];

  always_comb begin
    dout_nxt  = dout;  // FIFO path holds between beats
    valid_nxt = 1'b0;
    case (out_src)
      src_din: begin
        dout_nxt  = din;
        valid_nxt = 1'b1;
      end
      src_reg: begin
        dout_nxt  = reg_din;
        valid_nxt = 1'b1;
      end
      default: begin
        if (beat_valid)
          dout_nxt = fifo_beat;
        valid_nxt = beat_valid;
      end
    endcase
  end

  // One register stage for every path
  always_ff @(posedge m_ns_fwd_clk) begin
    if (reset) begin
      dout       <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout       <= dout_nxt;
      dout_valid <= valid_nxt;
    end
  end

endmodule

// ==== src/tx_phcomp_fifo.sv ====
`timescale 1ns/100ps
/* Transmit phase-compensation FIFO, show-ahead circular buffer
   with write source select and full/empty flags */
module tx_phcomp_fifo #(
  parameter int fifo_depth = 8  // Power of two, 4 or more
) (
  input  logic                          m_ns_fwd_clk,
  input  logic                          reset,
  input  logic                          wr_en,
  input  logic                          wr_sel_lpbk,
  input  logic [aib_tx_pkg::word_w-1:0] data_in,
  input  logic [aib_tx_pkg::word_w-1:0] rx_fifo_data_out,
  input  logic                          rd_en,
  output logic [aib_tx_pkg::word_w-1:0] rd_data,
  output logic                          full,
  output logic                          empty
);
  import aib_tx_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = ptr_w + 1;

  logic [word_w-1:0] mem [fifo_depth];
  logic [word_w-1:0] wr_data;
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  fill_cnt;

  assign wr_data = wr_sel_lpbk ? rx_fifo_data_out : data_in;  // Loopback 3 FIFO source
  assign rd_data = mem[rd_ptr];  // Head word visible before pop

  assign full  = (fill_cnt == cnt_w'(fifo_depth));
  assign empty = (fill_cnt == '0);

  always_ff @(posedge m_ns_fwd_clk) begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge m_ns_fwd_clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;  // Both or neither
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge m_ns_fwd_clk) disable iff (reset)
    wr_en |-> !full)
    else $error("FIFO written while full");

  a_no_underflow: assert property (@(posedge m_ns_fwd_clk) disable iff (reset)
    rd_en |-> !empty)
    else $error("FIFO read while empty");

endmodule

// ==== src/tx_chnl_ctrl.sv ====
`timescale 1ns/100ps
/* Transmit channel control: mode decode, four-phase req/ack handshake,
   phase-compensation read delay and double-write half stepping */
module tx_chnl_ctrl (
  input  logic                   m_ns_fwd_clk,
  input  logic                   reset,
  input  logic                   req,
  output logic                   ack,
  input  aib_tx_pkg::fifo_mode_e r_tx_fifo_mode,
  input  aib_tx_pkg::lpbk_mode_e r_tx_adapter_lpbk_mode,
  input  logic [2:0]             r_tx_phcomp_rd_delay,
  input  logic                   rx_fifo_valid,
  input  logic                   full,
  input  logic                   empty,
  output logic                   wr_en,
  output logic                   wr_sel_lpbk,
  output logic                   rd_en,
  output logic                   half_sel,
  output logic                   beat_valid,
  output logic                   reg_lpbk,
  output aib_tx_pkg::out_src_e   out_src
);
  import aib_tx_pkg::*;

  logic       lpbk2;
  logic       lpbk3_fifo;
  logic       fifo_path;    // FIFO beats drive dout
  logic       dbl_write;
  logic       user_open;    // User word may enter the FIFO
  logic       user_wr;
  logic       lpbk_wr;
  logic       mode_chg;
  logic       rd_started;
  logic [2:0] rd_dly_cnt;   // Consecutive non-empty cycles
  fifo_mode_e fifo_mode_q;
  lpbk_mode_e lpbk_mode_q;

  assign lpbk2      = (r_tx_adapter_lpbk_mode == lpbk_2);
  assign reg_lpbk   = (r_tx_adapter_lpbk_mode == lpbk_3_reg);
  assign lpbk3_fifo = (r_tx_adapter_lpbk_mode == lpbk_3_fifo);
  assign dbl_write  = (r_tx_fifo_mode == fifo_double);  // Reserved acts as single

  // Loopback 2 wins over every FIFO mode
  always_comb begin
    if (lpbk2)
      out_src = src_din;
    else if (reg_lpbk || r_tx_fifo_mode == fifo_reg)
      out_src = src_reg;
    else
      out_src = src_fifo;
  end

  assign fifo_path   = (out_src == src_fifo);
  assign user_open   = fifo_path && !lpbk3_fifo;
  assign user_wr     = user_open && req && !ack && !full;  // Same edge as ack rise
  assign lpbk_wr     = fifo_path && lpbk3_fifo && rx_fifo_valid && !full;
  assign wr_en       = user_wr || lpbk_wr;
  assign wr_sel_lpbk = lpbk3_fifo;

  // Beat 0 keeps the word, the last beat pops it
  assign beat_valid = fifo_path && rd_started && !empty;
  assign rd_en      = beat_valid && (!dbl_write || half_sel);

  assign mode_chg = (fifo_mode_q != r_tx_fifo_mode) ||
                    (lpbk_mode_q != r_tx_adapter_lpbk_mode);

  always_ff @(posedge m_ns_fwd_clk) begin
    if (reset) begin
      ack         <= 1'b0;
      fifo_mode_q <= fifo_single;
      lpbk_mode_q <= lpbk_none;
    end else begin
      fifo_mode_q <= r_tx_fifo_mode;
      lpbk_mode_q <= r_tx_adapter_lpbk_mode;
      if (user_wr)
        ack <= 1'b1;
      else if (!req)
        ack <= 1'b0;  // Four-phase return to idle
    end
  end

  // Reads wait until the FIFO stayed non-empty for delay+1 cycles
  always_ff @(posedge m_ns_fwd_clk) begin
    if (reset || mode_chg) begin
      rd_dly_cnt <= 3'd0;
      rd_started <= 1'b0;
    end else if (!rd_started) begin
      if (empty)
        rd_dly_cnt <= 3'd0;  // Streak broken
      else if (rd_dly_cnt == r_tx_phcomp_rd_delay)
        rd_started <= 1'b1;
      else
        rd_dly_cnt <= rd_dly_cnt + 3'd1;
    end
  end

  always_ff @(posedge m_ns_fwd_clk) begin
    if (reset || mode_chg)
      half_sel <= 1'b0;
    else if (beat_valid && dbl_write)
      half_sel <= ~half_sel;  // Low half, then high half
  end

  a_req_held: assert property (@(posedge m_ns_fwd_clk) disable iff (reset)
    (user_open && req && !ack) |=> (req || ack))
    else $error("req dropped before ack");

  a_lpbk_no_drop: assert property (@(posedge m_ns_fwd_clk) disable iff (reset)
    (fifo_path && lpbk3_fifo && rx_fifo_valid) |-> !full)
    else $error("loopback 3 FIFO word dropped on full FIFO");

endmodule

// ==== src/aib_tx_pkg.sv ====
/* AIB transmit channel shared definitions
   Beat and word widths, mode encodings and the output source select */
package aib_tx_pkg;

  localparam int beat_w = 40;  // One I/O beat
  localparam int word_w = 80;  // User word, beat 0 in low half

  // FIFO path mode, r_tx_fifo_mode
  typedef enum logic [1:0] {
    fifo_single = 2'b00,  // Low half only
    fifo_double = 2'b01,  // Low half then high half
    fifo_rsvd   = 2'b10,  // Same as single
    fifo_reg    = 2'b11   // Register path, FIFO bypassed
  } fifo_mode_e;

  // Adapter loopback mode, r_tx_adapter_lpbk_mode
  typedef enum logic [1:0] {
    lpbk_none   = 2'b00,
    lpbk_2      = 2'b01,  // Receive I/O data straight back
    lpbk_3_reg  = 2'b10,  // Receive register output via register path
    lpbk_3_fifo = 2'b11   // Receive FIFO output into transmit FIFO
  } lpbk_mode_e;

  // Which source the output stage registers onto dout
  typedef enum logic [1:0] {
    src_fifo = 2'b00,  // FIFO beats
    src_reg  = 2'b01,  // Register path
    src_din  = 2'b10   // Loopback 2
  } out_src_e;

endpackage
